// File: src/smc_config.svh
/* Static memory controller configuration */

`ifndef SMC_CONFIG_SVH
`define SMC_CONFIG_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define SMC_ADDR_W      16       // Memory address bits
`define SMC_DATA_W      32       // Data word bits
`define SMC_STRB_W      4        // One strobe per byte lane
`define SMC_WS_W        4        // Wait-state register bits

// ------------------------------
// Request buffer and config window
// ------------------------------
`define SMC_FIFO_DEPTH  4        // Queued requests

// Top address bit set, never forwarded to memory
`define SMC_CFG_ADDR    16'h8000
`define SMC_RESET_WS    2        // Wait states out of reset

`endif

// File: src/smc_pkg.sv
/* Static memory controller types */

`include "smc_config.svh"

package smc_pkg;

   // ------------------------------
   // Basic data types
   // ------------------------------
   typedef logic [`SMC_ADDR_W-1:0] addr_t;   // Memory address
   typedef logic [`SMC_DATA_W-1:0] data_t;   // Data word
   typedef logic [`SMC_STRB_W-1:0] strb_t;   // Byte strobes, high active
   typedef logic [`SMC_WS_W-1:0]   ws_t;     // Wait-state count

   // ------------------------------
   // Queued memory request
   // ------------------------------
   // One entry of the request buffer
   typedef struct packed
   {
      logic  write;   // 1 for a write, 0 for a read
      addr_t addr;    // Word address on the memory pins
      data_t data;    // Write data, unused on reads
      strb_t strb;    // Byte lanes of a write
   } smc_req_t;

   // ------------------------------
   // Sequencer states
   // ------------------------------
   typedef enum logic [1:0]
   {
      st_idle  = 2'd0,   // Waiting for a request
      st_lead  = 2'd1,   // Chip select only
      st_rw    = 2'd2,   // Strobes active, wait states counted here
      st_float = 2'd3    // Bus turnaround
   } smc_state_e;

endpackage

// File: src/smc_req_fifo.sv
/* Request buffer */

`timescale 1ns/1ps

`include "smc_config.svh"

module smc_req_fifo #(
   parameter type T = smc_pkg::smc_req_t   // Payload of one entry
) (
   input  logic  sys_clk6,
   input  logic  n_sys_reset6,
   input  logic  push,
   input  T      push_data,
   input  logic  pop,
   output T      pop_data,
   output logic  full,
   output logic  empty
);

   localparam int DEPTH = `SMC_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);   // Holds 0 to DEPTH

   T                  mem [DEPTH];   // Entry storage
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;         // Entries held
   logic              wr_en;
   logic              rd_en;

   // Guarded strobes, overflow and underflow dropped
   assign wr_en = push && !full;
   assign rd_en = pop && !empty;

   assign full     = (count == CNT_W'(DEPTH));
   assign empty    = (count == '0);
   assign pop_data = mem[rd_ptr];    // Head entry, valid when not empty

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
   begin
      if (!n_sys_reset6)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   // Storage write
   always_ff @(posedge sys_clk6)
   begin
      if (wr_en)
         mem[wr_ptr] <= push_data;
   end

endmodule

// File: src/smc_apb_front.sv
/* APB slave front end */

`timescale 1ns/1ps

`include "smc_config.svh"

module smc_apb_front (
   input  logic               sys_clk6,
   input  logic               n_sys_reset6,
   // APB slave
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  smc_pkg::addr_t     paddr,
   input  smc_pkg::data_t     pwdata,
   input  smc_pkg::strb_t     pstrb,
   output logic               pready,
   output smc_pkg::data_t     prdata,
   // Request buffer
   input  logic               full,
   output logic               push,
   output smc_pkg::smc_req_t  push_data,
   // Read return from the sequencer
   input  logic               rd_valid,
   input  smc_pkg::data_t     rd_data,
   // Wait states for the sequencer
   output smc_pkg::ws_t       wait_states
);

   logic            access;    // Access phase of a transfer
   logic            cfg_win;   // Local register window
   logic            cfg_hit;   // The wait-state register itself
   logic            mem_wr;    // Memory write in access phase
   logic            mem_rd;    // Memory read in access phase
   logic            rd_pend;   // Read pushed, transfer still open
   logic            rd_done;   // Read data back and held
   smc_pkg::data_t  rd_buf;    // Returned read word

   // ------------------------------
   // Transfer decode
   // ------------------------------
   assign access  = psel && penable;
   assign cfg_win = paddr[`SMC_ADDR_W-1];   // Top bit selects config space
   assign cfg_hit = (paddr == `SMC_CFG_ADDR);
   assign mem_wr  = access && !cfg_win && pwrite;
   assign mem_rd  = access && !cfg_win && !pwrite;

   // Writes go in while there is room, a read only once
   assign push = (mem_wr && !full) || (mem_rd && !rd_pend && !full);

   // Pack the request
   always_comb
   begin
      push_data.write = pwrite;
      push_data.addr  = paddr;
      push_data.data  = pwdata;
      push_data.strb  = pwrite ? pstrb : '1;   // Reads fetch the whole word
   end

   // ------------------------------
   // Ready and read data
   // ------------------------------
   always_comb
   begin
      if (cfg_win)
         pready = 1'b1;          // Local registers never wait
      else if (pwrite)
         pready = !full;         // Posted, stall only on a full buffer
      else
         pready = rd_done;       // Hold the bus until data is back
   end

   always_comb
   begin
      if (!cfg_win)
         prdata = rd_buf;
      else if (cfg_hit)
         prdata = smc_pkg::data_t'(wait_states);
      else
         prdata = '0;            // Unused part of the window
   end

   // ------------------------------
   // Outstanding read tracking
   // ------------------------------
   always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
   begin
      if (!n_sys_reset6)
      begin
         rd_pend <= 1'b0;
         rd_done <= 1'b0;
      end
      else if (mem_rd && rd_done)
      begin
         rd_pend <= 1'b0;        // Transfer ends this cycle
         rd_done <= 1'b0;
      end
      else
      begin
         if (mem_rd && !rd_pend && !full)
            rd_pend <= 1'b1;
         if (rd_valid && rd_pend)
            rd_done <= 1'b1;
      end
   end

   // Read word, payload only
   always_ff @(posedge sys_clk6)
   begin
      if (rd_valid)
         rd_buf <= rd_data;
   end

   // ------------------------------
   // Wait-state register
   // ------------------------------
   always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
   begin
      if (!n_sys_reset6)
         wait_states <= smc_pkg::ws_t'(`SMC_RESET_WS);
      else if (access && pwrite && cfg_hit)
         wait_states <= pwdata[`SMC_WS_W-1:0];   // Low bits only
   end

endmodule

// File: src/smc_strobe_seq.sv
/* Memory access sequencer */

`timescale 1ns/1ps

module smc_strobe_seq (
   input  logic               sys_clk6,
   input  logic               n_sys_reset6,
   // Request buffer
   input  logic               empty,
   input  smc_pkg::smc_req_t  pop_data,
   output logic               pop,
   // Wait states from the front end
   input  smc_pkg::ws_t       wait_states,
   // Read return
   output logic               rd_valid,
   output smc_pkg::data_t     rd_data,
   // Memory pins
   input  smc_pkg::data_t     smc_data_in,
   output smc_pkg::addr_t     smc_addr,
   output smc_pkg::data_t     smc_data_out,
   output logic               smc_n_cs,
   output logic               smc_n_rd,
   output smc_pkg::strb_t     smc_n_we,
   output logic               smc_n_wr,
   output logic               smc_n_ext_oe,
   output logic               smc_busy
);

   smc_pkg::smc_state_e  state_q;   // Current state
   smc_pkg::smc_req_t    req_q;     // Request being executed
   smc_pkg::ws_t         ws_cnt;    // Wait states left in rw
   logic                 cs_on;     // Lead or rw
   logic                 rw_read;   // Rw phase of a read
   logic                 rw_write;  // Rw phase of a write
   logic                 rd_last;   // Last cycle of the read strobe on the pins

   // ------------------------------
   // State decode
   // ------------------------------
   assign pop      = (state_q == smc_pkg::st_idle) && !empty;   // One request per idle
   assign cs_on    = (state_q == smc_pkg::st_lead) || (state_q == smc_pkg::st_rw);
   assign rw_read  = (state_q == smc_pkg::st_rw) && !req_q.write;
   assign rw_write = (state_q == smc_pkg::st_rw) && req_q.write;

   // Pins lag the state by one cycle, so float still shows the strobe
   assign rd_last  = (state_q == smc_pkg::st_float) && !req_q.write;

   // ------------------------------
   // Sequencer FSM
   // ------------------------------
   always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
   begin
      if (!n_sys_reset6)
      begin
         state_q <= smc_pkg::st_idle;
         ws_cnt  <= '0;
      end
      else
      begin
         case (state_q)
            smc_pkg::st_idle:
            begin
               if (!empty)
               begin
                  state_q <= smc_pkg::st_lead;
                  ws_cnt  <= wait_states;   // Sampled at pop
               end
            end
            smc_pkg::st_lead:
               state_q <= smc_pkg::st_rw;   // Single cycle
            smc_pkg::st_rw:
            begin
               if (ws_cnt == '0)
                  state_q <= smc_pkg::st_float;
               else
                  ws_cnt <= ws_cnt - 1'b1;  // Stretch by one cycle
            end
            smc_pkg::st_float:
               state_q <= smc_pkg::st_idle;
            default:
               state_q <= smc_pkg::st_idle;
         endcase
      end
   end

   // Request latch
   always_ff @(posedge sys_clk6)
   begin
      if (pop)
         req_q <= pop_data;
   end

   // ------------------------------
   // Control pins
   // ------------------------------
   always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
   begin
      if (!n_sys_reset6)
      begin
         smc_n_cs     <= 1'b1;
         smc_n_rd     <= 1'b1;
         smc_n_wr     <= 1'b1;
         smc_n_we     <= '1;
         smc_n_ext_oe <= 1'b1;
         smc_busy     <= 1'b0;
      end
      else
      begin
         smc_n_cs     <= !cs_on;
         smc_n_rd     <= !rw_read;                      // Whole rw phase
         smc_n_wr     <= !rw_write;
         smc_n_we     <= rw_write ? ~req_q.strb : '1;   // Active byte lanes
         smc_n_ext_oe <= !rw_write;                     // Drive bus on writes
         smc_busy     <= (state_q != smc_pkg::st_idle);
      end
   end

   // Address and write data, held from lead to the next request
   always_ff @(posedge sys_clk6)
   begin
      if (state_q == smc_pkg::st_lead)
      begin
         smc_addr     <= req_q.addr;
         smc_data_out <= req_q.data;
      end
   end

   // ------------------------------
   // Read return
   // ------------------------------
   always_ff @(posedge sys_clk6 or negedge n_sys_reset6)
   begin
      if (!n_sys_reset6)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_last;   // One-cycle pulse
   end

   // Sample at the edge that ends the read strobe
   always_ff @(posedge sys_clk6)
   begin
      if (rd_last)
         rd_data <= smc_data_in;
   end

endmodule

// File: src/smc_top.sv
/* Static memory controller top */

`timescale 1ns/1ps

module smc_top (
   input  logic            sys_clk6,
   input  logic            n_sys_reset6,
   // APB slave
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  smc_pkg::addr_t  paddr,
   input  smc_pkg::data_t  pwdata,
   input  smc_pkg::strb_t  pstrb,
   output logic            pready,
   output smc_pkg::data_t  prdata,
   output logic            pslverr,
   // Memory pins
   input  smc_pkg::data_t  smc_data_in,
   output smc_pkg::addr_t  smc_addr,
   output smc_pkg::data_t  smc_data_out,
   output logic            smc_n_cs,
   output logic            smc_n_rd,
   output smc_pkg::strb_t  smc_n_we,
   output logic            smc_n_wr,
   output logic            smc_n_ext_oe,
   output logic            smc_busy
);

   logic               push;
   smc_pkg::smc_req_t  push_data;
   logic               pop;
   smc_pkg::smc_req_t  pop_data;
   logic               full;
   logic               empty;
   logic               rd_valid;
   smc_pkg::data_t     rd_data;
   smc_pkg::ws_t       wait_states;

   assign pslverr = 1'b0;   // No error responses

   // ------------------------------
   // Front end, buffer, sequencer
   // ------------------------------
   smc_apb_front u_apb_front (
      .sys_clk6     (sys_clk6),
      .n_sys_reset6 (n_sys_reset6),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .pstrb        (pstrb),
      .pready       (pready),
      .prdata       (prdata),
      .full         (full),
      .push         (push),
      .push_data    (push_data),
      .rd_valid     (rd_valid),
      .rd_data      (rd_data),
      .wait_states  (wait_states)
   );

   smc_req_fifo #(
      .T (smc_pkg::smc_req_t)
   ) u_req_fifo (
      .sys_clk6     (sys_clk6),
      .n_sys_reset6 (n_sys_reset6),
      .push         (push),
      .push_data    (push_data),
      .pop          (pop),
      .pop_data     (pop_data),
      .full         (full),
      .empty        (empty)
   );

   smc_strobe_seq u_strobe_seq (
      .sys_clk6     (sys_clk6),
      .n_sys_reset6 (n_sys_reset6),
      .empty        (empty),
      .pop_data     (pop_data),
      .pop          (pop),
      .wait_states  (wait_states),
      .rd_valid     (rd_valid),
      .rd_data      (rd_data),
      .smc_data_in  (smc_data_in),
      .smc_addr     (smc_addr),
      .smc_data_out (smc_data_out),
      .smc_n_cs     (smc_n_cs),
      .smc_n_rd     (smc_n_rd),
      .smc_n_we     (smc_n_we),
      .smc_n_wr     (smc_n_wr),
      .smc_n_ext_oe (smc_n_ext_oe),
      .smc_busy     (smc_busy)
   );

endmodule

// File: bench/smc_tb.sv
/* SMC testbench */

`timescale 1ns/1ps

`include "smc_config.svh"

module smc_tb;

   localparam int CLK_PERIOD  = 10;
   localparam int LINE_CYCLES = 15 + 4;   // Longest request, in cycles

   // One memory access as it should appear on the pins
   typedef struct packed
   {
      logic        wr;
      logic [3:0]  strb;
      logic [15:0] addr;
      logic [7:0]  len;    // Strobe low cycles
   } strobe_exp_t;

   logic            sys_clk6;
   logic            n_sys_reset6;
   logic            psel;
   logic            penable;
   logic            pwrite;
   smc_pkg::addr_t  paddr;
   smc_pkg::data_t  pwdata;
   smc_pkg::strb_t  pstrb;
   logic            pready;
   smc_pkg::data_t  prdata;
   logic            pslverr;
   smc_pkg::data_t  smc_data_in;
   smc_pkg::addr_t  smc_addr;
   smc_pkg::data_t  smc_data_out;
   logic            smc_n_cs;
   logic            smc_n_rd;
   smc_pkg::strb_t  smc_n_we;
   logic            smc_n_wr;
   logic            smc_n_ext_oe;
   logic            smc_busy;

   smc_pkg::data_t  mem_words [0:65535];   // Memory model
   logic [31:0]     ref_words [int];       // Expected memory contents
   logic [31:0]     op_q [$];              // Trace columns
   logic [31:0]     addr_q [$];
   logic [31:0]     data_q [$];
   logic [31:0]     strb_q [$];
   logic [31:0]     exp_q [$];
   strobe_exp_t     strobe_q [$];          // Accesses not yet seen on the pins
   int              rd_run = 0;
   int              wr_run = 0;
   int              strobes_seen = 0;
   int              strobe_errs = 0;
   int              rule_errs = 0;
   int              op_errs = 0;
   int              pass_count = 0;
   int              fail_count = 0;
   int              write_stalls = 0;
   int              n_ops = 0;
   logic [3:0]      ws_model;              // Wait states the DUT should use
   logic [31:0]     lfsr_state;
   logic            trace_loaded = 1'b0;

   smc_top u_smc_top (.*);

   initial
   begin
      sys_clk6 = 1'b0;
      forever #(CLK_PERIOD / 2) sys_clk6 = ~sys_clk6;
   end

   // ------------------------------
   // Memory model
   // ------------------------------
   function automatic logic [31:0] fill_word(input logic [15:0] a);
      fill_word = {a, ~a} ^ 32'h9e37_79b9;   // Differs for every address
   endfunction

   assign smc_data_in = smc_n_rd ? '0 : mem_words[smc_addr];   // Only while read strobe is low

   always @(negedge sys_clk6)
   begin
      if (smc_n_wr === 1'b0)
      begin
         for (int b = 0; b < 4; b++)
            if (!smc_n_we[b])
               mem_words[smc_addr][8*b +: 8] = smc_data_out[8*b +: 8];   // Byte lane write
      end
   end

   // ------------------------------
   // Pin monitor
   // ------------------------------
   task automatic close_strobe(input logic wr, input int len);
      strobe_exp_t e;
      strobes_seen++;
      if (strobe_q.size() == 0)
      begin
         $display("Unexpected %s strobe at %0t ns with no access queued",
                  wr ? "write" : "read", $time);
         strobe_errs++;
      end
      else
      begin
         e = strobe_q.pop_front();
         if (e.wr !== wr)
         begin
            $display("Error %0t ns: %s strobe where the other kind was due", $time,
                     wr ? "write" : "read");
            strobe_errs++;
         end
         if (len != e.len)
         begin
            $display("Error %0t ns: %s strobe low %0d cycles, expected %0d", $time,
                     wr ? "write" : "read", len, e.len);
            strobe_errs++;
         end
      end
   endtask

   always @(negedge sys_clk6)
   begin
      if (n_sys_reset6)
      begin
         if (!smc_n_rd)
            rd_run++;
         else if (rd_run > 0)
         begin
            close_strobe(1'b0, rd_run);
            rd_run = 0;
         end
         if (!smc_n_wr)
            wr_run++;
         else if (wr_run > 0)
         begin
            close_strobe(1'b1, wr_run);
            wr_run = 0;
         end
         // Address and lanes of the access in progress
         if ((!smc_n_rd || !smc_n_wr) && strobe_q.size() > 0 && smc_addr !== strobe_q[0].addr)
         begin
            $display("Error %0t ns: address %h, expected %h", $time, smc_addr, strobe_q[0].addr);
            strobe_errs++;
         end
         if (!smc_n_wr && strobe_q.size() > 0 && smc_n_we !== ~strobe_q[0].strb)
         begin
            $display("Error %0t ns: byte enables %b, expected %b", $time, smc_n_we,
                     ~strobe_q[0].strb);
            strobe_errs++;
         end
         // Pin relations that hold on every cycle
         if (!smc_n_ext_oe && smc_n_wr)
         begin
            $display("Error %0t ns: output enable low without write strobe", $time);
            rule_errs++;
         end
         if (!smc_n_cs && !smc_busy)
         begin
            $display("Error %0t ns: chip select active while busy is low", $time);
            rule_errs++;
         end
         if ((!smc_n_rd || !smc_n_wr) && smc_n_cs)
         begin
            $display("Error %0t ns: strobe active outside chip select", $time);
            rule_errs++;
         end
         if (smc_n_wr && smc_n_we !== 4'hf)
         begin
            $display("Error %0t ns: byte enables %b with write strobe high", $time, smc_n_we);
            rule_errs++;
         end
         if (pslverr !== 1'b0)
         begin
            $display("Error %0t ns: pslverr raised", $time);
            rule_errs++;
         end
      end
   end

   // ------------------------------
   // Stimulus helpers
   // ------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic draw_gap(output int gap);
      gap = 0;
      repeat (2)
      begin
         lfsr_state = lfsr_next(lfsr_state);   // One step per bit
         gap = (gap << 1) | lfsr_state[0];
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(negedge sys_clk6);
         psel    = 1'b0;
         penable = 1'b0;
      end
   endtask

   task automatic expect_strobe(input logic wr, input logic [15:0] a, input logic [3:0] s);
      strobe_exp_t e;
      e.wr   = wr;
      e.strb = s;
      e.addr = a;
      e.len  = ws_model + 1;
      strobe_q.push_back(e);
   endtask

   // Setup and access phase, ends on the completing edge
   task automatic apb_transfer(input logic wr, input logic [15:0] a, input logic [31:0] d,
                               input logic [3:0] s, output logic [31:0] rdata,
                               output int stalls);
      stalls = 0;
      @(negedge sys_clk6);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = a;
      pwdata  = wr ? d : '0;
      pstrb   = wr ? s : '0;
      @(negedge sys_clk6);
      penable = 1'b1;
      #(CLK_PERIOD / 4);               // Ready is settled mid low phase
      while (!pready)
      begin
         stalls++;
         @(negedge sys_clk6);
         #(CLK_PERIOD / 4);
      end
      rdata = prdata;
      @(posedge sys_clk6);
   endtask

   // Wait until every queued access has left the pins
   task automatic drain_requests;
      idle_cycles(1);
      #(CLK_PERIOD / 4);
      while (strobe_q.size() != 0 || smc_busy)
      begin
         @(negedge sys_clk6);
         #(CLK_PERIOD / 4);
      end
   endtask

   task automatic report_test(input string name, input logic ok);
      if (ok)
      begin
         pass_count++;
         $display("%s: passed", name);
      end
      else
      begin
         fail_count++;
         $display("%s: failed", name);
      end
   endtask

   task automatic load_trace;
      int               fd;
      int               n;
      logic [8*128-1:0] line_buf;
      logic [31:0]      op;
      logic [31:0]      a;
      logic [31:0]      d;
      logic [31:0]      s;
      logic [31:0]      e;
      fd = $fopen("bench/smc_trace.txt", "r");
      if (fd == 0)
         $display("Could not open the trace file bench/smc_trace.txt");
      else
      begin
         while ($fgets(line_buf, fd) != 0)
         begin
            n = $sscanf(line_buf, "%s %h %h %h %h", op, a, d, s, e);
            if (n == 5)                // Comment lines never match all five
            begin
               op_q.push_back(op);
               addr_q.push_back(a);
               data_q.push_back(d);
               strb_q.push_back(s);
               exp_q.push_back(e);
            end
         end
         $fclose(fd);
         n_ops = op_q.size();
         trace_loaded = 1'b1;          // Arms the watchdog
      end
   endtask

   // ------------------------------
   // One trace operation
   // ------------------------------
   task automatic run_op(input int idx);
      logic [31:0]    op;
      logic [15:0]    a;
      logic [31:0]    d;
      logic [3:0]     s;
      logic [31:0]    want;
      logic [31:0]    got;
      logic [31:0]    mask;
      int             stalls;
      int             gap;
      string          kind;
      op      = op_q[idx];
      a       = addr_q[idx][15:0];
      d       = data_q[idx];
      s       = strb_q[idx][3:0];
      op_errs = 0;
      kind    = "unknown";
      draw_gap(gap);
      idle_cycles(gap);
      case (op)
         "wr":
         begin
            kind = "write";
            expect_strobe(1'b1, a, s);
            apb_transfer(1'b1, a, d, s, got, stalls);
            write_stalls += stalls;
            mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
            want = ref_words.exists(a) ? ref_words[a] : fill_word(a);
            ref_words[a] = (want & ~mask) | (d & mask);   // Merge by byte
         end
         "rd":
         begin
            kind = "read";
            expect_strobe(1'b0, a, 4'hf);
            apb_transfer(1'b0, a, '0, '0, got, stalls);
            want = ref_words.exists(a) ? ref_words[a] : fill_word(a);
            if (got !== want)
            begin
               $display("Error %0t ns: read %h returned %h, expected %h", $time, a, got, want);
               op_errs++;
            end
            if (got !== exp_q[idx])
            begin
               $display("Error %0t ns: read %h returned %h, trace expects %h", $time, a, got,
                        exp_q[idx]);
               op_errs++;
            end
         end
         "cw":
         begin
            kind = "config write";
            drain_requests();          // Queued accesses keep the old wait states
            apb_transfer(1'b1, a, d, s, got, stalls);
            ws_model = d[3:0];
         end
         "cr":
         begin
            kind = "config read";
            apb_transfer(1'b0, a, '0, '0, got, stalls);
            if (got !== {28'h0, ws_model} || got !== exp_q[idx])
            begin
               $display("Error %0t ns: config read returned %h, expected %h", $time, got,
                        exp_q[idx]);
               op_errs++;
            end
         end
         default:
         begin
            $display("Trace line %0d holds an operation this bench does not know", idx);
            op_errs++;
         end
      endcase
      report_test($sformatf("op %0d %s %h", idx, kind, a), op_errs == 0);
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial
   begin
      n_sys_reset6 = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      pstrb        = '0;
      lfsr_state   = 32'h71a792e1;
      ws_model     = `SMC_RESET_WS;
      for (int i = 0; i < 65536; i++)
         mem_words[i] = fill_word(i[15:0]);
      load_trace();

      repeat (4) @(posedge sys_clk6);
      @(negedge sys_clk6);
      n_sys_reset6 = 1'b1;
      @(negedge sys_clk6);
      if (smc_n_cs !== 1'b1 || smc_n_rd !== 1'b1 || smc_n_wr !== 1'b1 ||
          smc_n_ext_oe !== 1'b1 || smc_n_we !== 4'hf || smc_busy !== 1'b0)
      begin
         $display("Error %0t ns: pins not idle after reset", $time);
         op_errs++;
      end
      report_test("pins idle after reset", op_errs == 0);
      report_test("trace file read", n_ops > 0);

      for (int i = 0; i < n_ops; i++)
         run_op(i);
      drain_requests();

      if (strobes_seen == 0)
         $display("No read or write strobe was seen on the pins");
      report_test("strobe widths", strobe_errs == 0 && strobes_seen > 0);
      report_test("pin relations", rule_errs == 0);
      if (write_stalls == 0)
         $display("No write was held off by a full request buffer");
      report_test("write back-pressure", write_stalls > 0);

      $display("Tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   // Watchdog sized from the trace length
   initial
   begin
      longint limit_ns;
      wait (trace_loaded);
      limit_ns = longint'(n_ops) * LINE_CYCLES * CLK_PERIOD * 4;
      #(limit_ns);
      $display("Run did not finish within %0d ns", limit_ns);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: bench/smc_trace.txt
# op addr data strb expect, op is wr rd cw (config write) or cr (config read)
# values in hex, expect is the read result and is ignored for wr and cw
cr 8000 00000000 0 00000002
wr 0010 11223344 f 00000000
rd 0010 00000000 0 11223344
wr 0010 aabbccdd 5 00000000
rd 0010 00000000 0 11bb33dd
cw 8000 00000000 f 00000000
wr 0020 01234567 f 00000000
wr 0020 ffffffff a 00000000
rd 0020 00000000 0 ff23ff67
cw 8000 00000009 f 00000000
cr 8000 00000000 0 00000009
wr 0100 d0000100 f 00000000
wr 0101 d1000101 f 00000000
wr 0102 d2000102 f 00000000
wr 0103 d3000103 f 00000000
wr 0104 d4000104 f 00000000
wr 0105 d5000105 f 00000000
wr 0106 d6000106 f 00000000
wr 0107 d7000107 f 00000000
rd 0100 00000000 0 d0000100
rd 0101 00000000 0 d1000101
rd 0102 00000000 0 d2000102
rd 0103 00000000 0 d3000103
rd 0104 00000000 0 d4000104
rd 0105 00000000 0 d5000105
rd 0106 00000000 0 d6000106
rd 0107 00000000 0 d7000107

// File: files.f
+incdir+src
src/smc_pkg.sv
src/smc_req_fifo.sv
src/smc_apb_front.sv
src/smc_strobe_seq.sv
src/smc_top.sv
bench/smc_tb.sv

// File: Bender.yml
package:
  name: smc_lite

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/smc_pkg.sv
      - src/smc_req_fifo.sv
      - src/smc_apb_front.sv
      - src/smc_strobe_seq.sv
      - src/smc_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/smc_tb.sv
